/* fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Machine word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define XLEN 32

// First address fetched after reset.
`define RESET_VECTOR 32'h80000000

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction cache geometry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define ICACHE_LINES 16  // Direct mapped with one tag per line.
`define LINE_WORDS 4     // A refill always moves a whole line.

`endif

/* isa_pkg.sv */
`include "fetch_defs.svh"

package isa_pkg;

  typedef logic [`XLEN-1:0] addr_t;
  typedef logic [`XLEN-1:0] inst_t;
  typedef logic [4:0] opcode_t;  // Bits 6 to 2. The low two bits are always 11.

  localparam opcode_t OP_BRANCH = 5'b11000;
  localparam opcode_t OP_JAL = 5'b11011;

  function automatic opcode_t opcode_of(inst_t i);
    return i[6:2];
  endfunction

  // B-type immediate, sign extended, bit 0 always clear.
  function automatic addr_t imm_b(inst_t i);
    return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
  endfunction

  // J-type immediate as used by JAL.
  function automatic addr_t imm_j(inst_t i);
    return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
  endfunction

endpackage

/* fetch_pkg.sv */
`include "fetch_defs.svh"

package fetch_pkg;

  // Address split for the instruction cache.
  localparam int OFFSET_LSB = 2;  // Byte offset within a word is ignored.
  localparam int OFFSET_BITS = $clog2(`LINE_WORDS);
  localparam int INDEX_LSB = OFFSET_LSB + OFFSET_BITS;
  localparam int INDEX_BITS = $clog2(`ICACHE_LINES);

  // The tag is taken from the top of the address and overlaps the upper index bits.
  localparam int TAG_BITS = `XLEN - INDEX_BITS - OFFSET_BITS;

  typedef logic [INDEX_BITS-1:0] line_index_t;
  typedef logic [OFFSET_BITS-1:0] line_offset_t;
  typedef logic [TAG_BITS-1:0] tag_t;

  typedef enum logic {
    FETCH_WAIT,
    FETCH_HOLD
  } fetch_state_t;

  typedef enum logic [1:0] {
    REFILL_IDLE,
    REFILL_REQ,
    REFILL_FILL
  } refill_state_t;

endpackage

/* icache.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module icache import isa_pkg::*, fetch_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  fencei,
  input  addr_t fetch_addr,
  output logic  hit,
  output inst_t inst,
  output logic  mem_req,
  output addr_t mem_addr,
  input  logic  mem_rvalid,
  input  inst_t mem_rdata
);

  function automatic line_index_t index_of(addr_t a);
    return a[INDEX_LSB +: INDEX_BITS];
  endfunction

  function automatic line_offset_t offset_of(addr_t a);
    return a[OFFSET_LSB +: OFFSET_BITS];
  endfunction

  function automatic tag_t tag_of(addr_t a);
    return a[`XLEN-1 -: TAG_BITS];
  endfunction

  inst_t data_mem [`ICACHE_LINES][`LINE_WORDS];
  tag_t tag_mem [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] line_valid;

  refill_state_t state;
  addr_t refill_addr;        // Line aligned.
  line_index_t refill_index;
  line_offset_t word_cnt;
  logic last_word;
  logic poisoned;            // Set when fencei lands during a refill.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lookup.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign hit = line_valid[index_of(fetch_addr)] &&
               (tag_mem[index_of(fetch_addr)] == tag_of(fetch_addr));
  assign inst = data_mem[index_of(fetch_addr)][offset_of(fetch_addr)];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Refill.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign refill_index = index_of(refill_addr);
  assign last_word = (word_cnt == line_offset_t'(`LINE_WORDS - 1));

  assign mem_req = (state == REFILL_REQ);  // Exactly one cycle per refill.
  assign mem_addr = refill_addr;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= REFILL_IDLE;
      line_valid <= '0;
      word_cnt <= '0;
      poisoned <= 1'b0;
    end else begin
      case (state)
        REFILL_IDLE: begin
          if (!hit) begin
            state <= REFILL_REQ;
            poisoned <= 1'b0;
            // The victim line stops hitting while its words are replaced.
            line_valid[index_of(fetch_addr)] <= 1'b0;
          end
        end
        REFILL_REQ: begin
          state <= REFILL_FILL;
          word_cnt <= '0;
        end
        REFILL_FILL: begin
          if (mem_rvalid) begin
            word_cnt <= line_offset_t'(word_cnt + 1'b1);
            if (last_word) begin
              state <= REFILL_IDLE;
              line_valid[refill_index] <= ~poisoned;
            end
          end
        end
        default: state <= REFILL_IDLE;
      endcase

      // Invalidation wins over a line finishing on the same cycle.
      if (fencei) begin
        line_valid <= '0;
        if (state != REFILL_IDLE) poisoned <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == REFILL_IDLE && !hit) begin
      refill_addr <= {fetch_addr[`XLEN-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
    end
    if (state == REFILL_FILL && mem_rvalid) begin
      data_mem[refill_index][word_cnt] <= mem_rdata;
      if (last_word) tag_mem[refill_index] <= tag_of(refill_addr);
    end
  end

endmodule

/* ifu.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module ifu import isa_pkg::*, fetch_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  flush,
  input  addr_t dnpc,
  output addr_t fetch_addr,
  input  logic  hit,
  input  inst_t inst,
  output logic  fetch_valid,
  input  logic  fetch_ready,
  output addr_t fetch_pc,
  output inst_t fetch_inst
);

  fetch_state_t state, state_next;
  addr_t pc, pc_next;
  addr_t pc_step, pc_pred;
  addr_t redirect_pc;       // Target of a flush seen during a miss.
  logic out_valid, out_valid_next;
  logic flush_pending, flush_pending_next;
  logic space;
  logic capture;

  assign fetch_addr = pc;
  assign fetch_valid = out_valid & ~flush;  // A word offered during a flush is dropped.
  assign space = ~out_valid | fetch_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Static prediction.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Backward branches are taken, everything else falls through.
  assign pc_step = (opcode_of(inst) == OP_BRANCH && inst[31]) ? imm_b(inst) : addr_t'(4);
  assign pc_pred = pc + pc_step;

  always_comb begin
    state_next = state;
    pc_next = pc;
    out_valid_next = out_valid;
    flush_pending_next = flush_pending;
    capture = 1'b0;

    case (state)
      FETCH_WAIT: begin
        if (hit) begin
          if (flush || flush_pending) begin
            flush_pending_next = 1'b0;
            out_valid_next = 1'b0;
            pc_next = flush ? dnpc : redirect_pc;
          end else if (space) begin
            capture = 1'b1;
          end else begin
            state_next = FETCH_HOLD;
          end
        end else if (flush) begin
          // Let the refill finish and redirect once the line is in.
          flush_pending_next = 1'b1;
          out_valid_next = 1'b0;
        end else if (fetch_ready) begin
          out_valid_next = 1'b0;
        end
      end
      FETCH_HOLD: begin
        if (flush) begin
          state_next = FETCH_WAIT;
          out_valid_next = 1'b0;
          pc_next = dnpc;
        end else if (space) begin
          state_next = FETCH_WAIT;
          if (hit) begin
            capture = 1'b1;
          end else begin
            out_valid_next = 1'b0;  // The held line was invalidated meanwhile.
          end
        end
      end
      default: state_next = FETCH_WAIT;
    endcase

    if (capture) begin
      out_valid_next = 1'b1;
      pc_next = pc_pred;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= FETCH_WAIT;
      pc <= `RESET_VECTOR;
      out_valid <= 1'b0;
      flush_pending <= 1'b0;
    end else begin
      state <= state_next;
      pc <= pc_next;
      out_valid <= out_valid_next;
      flush_pending <= flush_pending_next;
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      fetch_pc <= pc;
      fetch_inst <= inst;
    end
    if (flush) redirect_pc <= dnpc;
  end

endmodule

/* jump_redirect.sv */
`timescale 1ns/1ns

module jump_redirect import isa_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  fetch_valid,
  output logic  fetch_ready,
  input  addr_t fetch_pc,
  input  inst_t fetch_inst,
  output logic  flush,
  output addr_t dnpc,
  output logic  issue_valid,
  input  logic  issue_ready,
  output addr_t issue_pc,
  output inst_t issue_inst
);

  logic accept;
  logic is_jal;

  // The single entry takes a new word when empty or when it drains this cycle.
  assign fetch_ready = ~issue_valid | issue_ready;
  assign accept = fetch_valid & fetch_ready;
  assign is_jal = (opcode_of(fetch_inst) == OP_JAL);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Issue register and redirect.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (reset) begin
      issue_valid <= 1'b0;
      flush <= 1'b0;
    end else begin
      if (accept) begin
        issue_valid <= 1'b1;
      end else if (issue_ready) begin
        issue_valid <= 1'b0;
      end
      flush <= accept & is_jal;  // One cycle pulse per accepted JAL.
    end
  end

  // Target is only looked at while flush is high.
  always_ff @(posedge clock) begin
    if (accept) begin
      issue_pc <= fetch_pc;
      issue_inst <= fetch_inst;
      dnpc <= fetch_pc + imm_j(fetch_inst);
    end
  end

endmodule

/* fetch_top.sv */
`timescale 1ns/1ns

module fetch_top import isa_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  fencei,
  output logic  issue_valid,
  input  logic  issue_ready,
  output addr_t issue_pc,
  output inst_t issue_inst,
  output logic  mem_req,
  output addr_t mem_addr,
  input  logic  mem_rvalid,
  input  inst_t mem_rdata
);

  // Cache lookup.
  addr_t fetch_addr;
  logic  hit;
  inst_t inst;

  // Fetch to decode handshake.
  logic  fetch_valid;
  logic  fetch_ready;
  addr_t fetch_pc;
  inst_t fetch_inst;

  // Redirect back to fetch.
  logic  flush;
  addr_t dnpc;

  icache icache (
    .clock      (clock),
    .reset      (reset),
    .fencei     (fencei),
    .fetch_addr (fetch_addr),
    .hit        (hit),
    .inst       (inst),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata)
  );

  ifu ifu (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .dnpc        (dnpc),
    .fetch_addr  (fetch_addr),
    .hit         (hit),
    .inst        (inst),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch_pc    (fetch_pc),
    .fetch_inst  (fetch_inst)
  );

  jump_redirect jump_redirect (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch_pc    (fetch_pc),
    .fetch_inst  (fetch_inst),
    .flush       (flush),
    .dnpc        (dnpc),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_pc    (issue_pc),
    .issue_inst  (issue_inst)
  );

endmodule

/* fetch_asserts.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_asserts import isa_pkg::*; (
  input logic  clock,
  input logic  reset,
  input logic  fencei,
  input logic  flush,
  input logic  issue_valid,
  input logic  issue_ready,
  input addr_t issue_pc,
  input inst_t issue_inst,
  input logic  mem_req,
  input addr_t mem_addr,
  input logic  mem_rvalid
);

  logic refill_open;          // From mem_req to the last returned word.
  logic [2:0] words_seen;
  logic inval_wait;           // From fencei to the next mem_req.
  logic [2:0] stale_issues;
  logic [6:0] inval_cycles;

  always_ff @(posedge clock) begin
    if (reset) begin
      refill_open <= 1'b0;
      words_seen <= '0;
      inval_wait <= 1'b0;
      stale_issues <= '0;
      inval_cycles <= '0;
    end else begin
      if (mem_req) begin
        refill_open <= 1'b1;
        words_seen <= '0;
      end else if (mem_rvalid) begin
        words_seen <= words_seen + 3'd1;
        if (words_seen == 3'(`LINE_WORDS - 1)) refill_open <= 1'b0;
      end
      if (fencei) begin
        inval_wait <= 1'b1;
        stale_issues <= '0;
        inval_cycles <= '0;
      end else if (mem_req) begin
        inval_wait <= 1'b0;
      end else if (inval_wait) begin
        inval_cycles <= inval_cycles + 7'd1;
        if (issue_valid && issue_ready) stale_issues <= stale_issues + 3'd1;
      end
    end
  end

  reset_quiet: assert property (@(posedge clock) reset |=> !issue_valid && !mem_req && !flush)
    else $error("Issue, refill or flush active right after a reset cycle");

  issue_hold: assert property (@(posedge clock) disable iff (reset)
      issue_valid && !issue_ready |=> issue_valid && $stable(issue_pc) && $stable(issue_inst))
    else $error("Issue port changed while stalled");

  one_refill: assert property (@(posedge clock) disable iff (reset) mem_req |-> !refill_open)
    else $error("Refill requested while another one is outstanding");

  req_pulse: assert property (@(posedge clock) disable iff (reset) mem_req |=> !mem_req)
    else $error("Refill request longer than one cycle");

  line_aligned: assert property (@(posedge clock) disable iff (reset)
      mem_req |-> (mem_addr & addr_t'(`LINE_WORDS * 4 - 1)) == '0)
    else $error("Refill address not aligned to a line");

  flush_pulse: assert property (@(posedge clock) disable iff (reset) flush |=> !flush)
    else $error("Flush longer than one cycle");

  // Only the two words already in flight may issue before the refetch.
  refetch_first: assert property (@(posedge clock) disable iff (reset)
      inval_wait && issue_valid && issue_ready |-> stale_issues < 3'd2)
    else $error("Instructions issued after fencei without a refill");

  refetch_soon: assert property (@(posedge clock) disable iff (reset)
      inval_wait |-> inval_cycles < 7'd100)
    else $error("No refill followed fencei");

endmodule

bind fetch_top fetch_asserts asserts (
  .clock       (clock),
  .reset       (reset),
  .fencei      (fencei),
  .flush       (flush),
  .issue_valid (issue_valid),
  .issue_ready (issue_ready),
  .issue_pc    (issue_pc),
  .issue_inst  (issue_inst),
  .mem_req     (mem_req),
  .mem_addr    (mem_addr),
  .mem_rvalid  (mem_rvalid)
);

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;  // 40 ns period.
  end

  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

/* tb_fetch.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module tb_fetch import isa_pkg::*; ();

  localparam int MEM_WORDS = 32;
  localparam int INDEX_BITS = $clog2(MEM_WORDS);
  localparam int ISSUE_TARGET = 300;
  localparam int FENCEI_AT = 150;  // Issued count at which the cache is invalidated.
  // Roughly 2.5 cycles per issued word including misses. The margin is four.
  localparam int CYCLE_LIMIT = 4 * (ISSUE_TARGET * 5 / 2);

  logic clock;
  logic reset;
  logic fencei = 1'b0;
  logic issue_ready = 1'b0;
  logic mem_rvalid = 1'b0;
  inst_t mem_rdata = '0;
  logic issue_valid;
  addr_t issue_pc;
  inst_t issue_inst;
  logic mem_req;
  addr_t mem_addr;

  inst_t image [MEM_WORDS];
  logic [15:0] lfsr = 16'd97;

  logic refilling = 1'b0;
  addr_t refill_base = '0;
  int words_sent = 0;
  logic [1:0] gap = '0;      // Idle cycles before the next returned word.

  addr_t expected_pc = `RESET_VECTOR;
  logic fencei_sent = 1'b0;
  int issued = 0;
  int refills = 0;
  int errors = 0;
  int cycles = 0;

  tb_clock clock_gen (
    .clock (clock),
    .reset (reset)
  );

  fetch_top UUT (
    .clock       (clock),
    .reset       (reset),
    .fencei      (fencei),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_pc    (issue_pc),
    .issue_inst  (issue_inst),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_rvalid  (mem_rvalid),
    .mem_rdata   (mem_rdata)
  );

  initial $readmemh("program.hex", image);

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function logic random_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  function logic [1:0] draw_gap();
    logic [1:0] g;
    g[1] = random_bit();
    g[0] = random_bit();
    return g;
  endfunction

  function automatic inst_t word_at(addr_t a);
    addr_t offset;
    offset = a - `RESET_VECTOR;
    if (offset < addr_t'(MEM_WORDS * 4)) return image[offset[INDEX_BITS+1:2]];
    return a ^ 32'h5a5a_5a5a;  // Outside the image a word follows from its address.
  endfunction

  // JAL and backward branches jump in the static program flow. The rest falls through.
  function automatic addr_t next_pc(addr_t pc, inst_t w);
    addr_t jump_off;
    addr_t branch_off;
    jump_off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    branch_off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    if (w[6:0] == 7'b1101111) return pc + jump_off;
    if (w[6:0] == 7'b1100011 && w[31]) return pc + branch_off;
    return pc + 32'd4;
  endfunction

  task finish_run(input logic timed_out);
    if (timed_out) $display("Run timed out after %0d cycles", cycles);
    $display("Issued %0d, refills %0d, errors %0d, cycles %0d", issued, refills, errors, cycles);
    if (errors == 0 && !timed_out) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  always @(posedge clock) begin
    mem_rvalid <= 1'b0;
    fencei <= 1'b0;
    if (reset) begin
      issue_ready <= 1'b0;
    end else begin
      cycles = cycles + 1;
      if (issue_valid && issue_ready) begin
        assert (issue_pc == expected_pc) else begin
          errors = errors + 1;
          $display("Error at %0t: issued pc %h, expected %h", $time, issue_pc, expected_pc);
        end
        assert (issue_inst == word_at(issue_pc)) else begin
          errors = errors + 1;
          $display("Error at %0t: word %h at pc %h, image holds %h", $time, issue_inst,
                   issue_pc, word_at(issue_pc));
        end
        expected_pc = next_pc(expected_pc, word_at(expected_pc));
        issued = issued + 1;
      end

      issue_ready <= random_bit();
      if (!fencei_sent && issued >= FENCEI_AT) begin
        fencei <= 1'b1;
        fencei_sent = 1'b1;
      end

      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // Instruction memory.
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      if (mem_req) begin
        refill_base = mem_addr;
        words_sent = 0;
        gap = draw_gap();
        refilling = 1'b1;
        refills = refills + 1;
      end else if (refilling) begin
        if (gap != 2'd0) begin
          gap = gap - 2'd1;
        end else begin
          mem_rvalid <= 1'b1;
          mem_rdata <= word_at(refill_base + addr_t'(4 * words_sent));
          words_sent = words_sent + 1;
          if (words_sent == `LINE_WORDS) refilling = 1'b0;
          else gap = draw_gap();
        end
      end
    end

    if (issued == ISSUE_TARGET) begin
      finish_run(1'b0);
    end else if (cycles == CYCLE_LIMIT) begin
      finish_run(1'b1);
    end
  end

endmodule

/* program.hex */
// One instruction word per line, in hex.
// Line n holds the word at RESET_VECTOR + 4 * n.
00100093
00200113
00300193
00208233
004182b3
00600313
00700393
00000013
00208663
00140413
00c0006f
fff00493
ffe00493
00150513
008505b3
00000013
00c00613
00000013
00000013
00168693
fc0098e3
01500f93
01600f93
01700f93
01800f93
01900f93
01a00f93
01b00f93
01c00f93
01d00f93
01e00f93
01f00f93

/* filelist.f */
+incdir+.
isa_pkg.sv
fetch_pkg.sv
icache.sv
ifu.sv
jump_redirect.sv
fetch_top.sv
fetch_asserts.sv
tb_clock.sv
tb_fetch.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_fetch -f filelist.f \
  && ./obj_dir/Vtb_fetch | tee sim.log \
  || echo "Build or simulation stopped with an error"
grep -qx "Testbench passed" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
